/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

    // Datapath width and register file geometry
    localparam int unsigned XLEN        = 32;
    localparam int unsigned REG_NUM     = 32;
    localparam int unsigned REG_IDX_LEN = 5;

    // Immediate field width, as in the RISC-V I-type format
    localparam int unsigned IMM_LEN = 12;

    // One architectural data word
    typedef logic [XLEN-1:0] word_t;

    // Register index, x0 to x31
    typedef logic [REG_IDX_LEN-1:0] reg_idx_t;

    // Signed immediate, sign extended inside the ALU
    typedef logic signed [IMM_LEN-1:0] imm_t;

    // ALU opcode
    typedef logic [2:0] alu_op_t;

    // Register-register operations
    localparam alu_op_t OP_ADD = 3'd0;
    localparam alu_op_t OP_SUB = 3'd1;
    localparam alu_op_t OP_AND = 3'd2;
    localparam alu_op_t OP_OR  = 3'd3;
    localparam alu_op_t OP_XOR = 3'd4;
    // Shift amount is the low 5 bits of rs2
    localparam alu_op_t OP_SLL = 3'd5;
    localparam alu_op_t OP_SRL = 3'd6;
    // Register-immediate add, rs2 is ignored
    localparam alu_op_t OP_ADDI = 3'd7;

endpackage

`default_nettype wire

/* instr_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_fifo
    import exec_pkg::*;
#(
    parameter int unsigned ISSUE_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Write side, from the instruction channel
    input  logic     push_i,
    input  alu_op_t  push_op_i,
    input  reg_idx_t push_rd_i,
    input  reg_idx_t push_rs1_i,
    input  reg_idx_t push_rs2_i,
    input  imm_t     push_imm_i,

    // Read side, towards issue control
    input  logic     pop_i,
    output alu_op_t  head_op_o,
    output reg_idx_t head_rd_o,
    output reg_idx_t head_rs1_o,
    output reg_idx_t head_rs2_o,
    output imm_t     head_imm_o,
    output logic     empty_o
);

    // Pointer and occupancy widths, at least one bit each
    localparam int unsigned PTR_LEN = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
    localparam int unsigned CNT_LEN = $clog2(ISSUE_DEPTH + 1);

    // Entry storage, one array per field
    alu_op_t  op_mem  [ISSUE_DEPTH];
    reg_idx_t rd_mem  [ISSUE_DEPTH];
    reg_idx_t rs1_mem [ISSUE_DEPTH];
    reg_idx_t rs2_mem [ISSUE_DEPTH];
    imm_t     imm_mem [ISSUE_DEPTH];

    logic [PTR_LEN-1:0] wr_ptr_q;
    logic [PTR_LEN-1:0] rd_ptr_q;
    logic [CNT_LEN-1:0] count_q;

    // Advance a pointer with wrap at the last entry
    function automatic logic [PTR_LEN-1:0] next_ptr(input logic [PTR_LEN-1:0] ptr);
        logic [PTR_LEN-1:0] nxt;
        if (ptr == PTR_LEN'(ISSUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Pointers and occupancy count
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Simultaneous push and pop leaves the count unchanged
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (!push_i && pop_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Payload write, no reset on storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            op_mem[wr_ptr_q]  <= push_op_i;
            rd_mem[wr_ptr_q]  <= push_rd_i;
            rs1_mem[wr_ptr_q] <= push_rs1_i;
            rs2_mem[wr_ptr_q] <= push_rs2_i;
            imm_mem[wr_ptr_q] <= push_imm_i;
        end
    end

    // Oldest entry is always at the read pointer
    assign head_op_o  = op_mem[rd_ptr_q];
    assign head_rd_o  = rd_mem[rd_ptr_q];
    assign head_rs1_o = rs1_mem[rd_ptr_q];
    assign head_rs2_o = rs2_mem[rd_ptr_q];
    assign head_imm_o = imm_mem[rd_ptr_q];
    assign empty_o    = (count_q == '0);

endmodule

`default_nettype wire

/* issue_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl
    import exec_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Queue head
    input  logic     empty_i,
    input  reg_idx_t head_rd_i,
    input  reg_idx_t head_rs1_i,
    input  reg_idx_t head_rs2_i,

    // Issue outputs
    output logic     pop_o,
    output logic     issue_valid_o,
    output logic     credit_o,

    // Write-back from the ALU pipeline
    input  logic     wb_valid_i,
    input  reg_idx_t wb_rd_i
);

    // One bit per register, set while a result is pending
    logic [REG_NUM-1:0] busy_q;
    logic [REG_NUM-1:0] busy_d;

    logic rs1_busy;
    logic rs2_busy;
    logic rd_busy;
    logic issue;
    logic credit_q;

    // Scoreboard lookup for the head entry
    // x0 bit is never set, so reads of x0 never stall
    assign rs1_busy = busy_q[head_rs1_i];
    assign rs2_busy = busy_q[head_rs2_i];

    // An older pending write to the same rd would clear the bit early
    // on its write-back, so the head also waits for its own rd
    assign rd_busy = busy_q[head_rd_i];

    // Issue decision, purely combinational
    assign issue = !empty_i && !rs1_busy && !rs2_busy && !rd_busy;

    assign pop_o         = issue;
    assign issue_valid_o = issue;

    // Next scoreboard state
    always_comb begin
        busy_d = busy_q;
        // Clear on write-back, same edge as the register file write
        if (wb_valid_i) begin
            busy_d[wb_rd_i] = 1'b0;
        end
        // Set on issue, applied last so that it wins over a clear
        if (issue && (head_rd_i != '0)) begin
            busy_d[head_rd_i] = 1'b1;
        end
        // x0 never holds a pending result
        busy_d[0] = 1'b0;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // Credit pulse in the cycle after the entry leaves the queue
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_q <= 1'b0;
        end else begin
            credit_q <= issue;
        end
    end

    assign credit_o = credit_q;

endmodule

`default_nettype wire

/* int_rf.sv */
`timescale 1ns/1ns
`default_nettype none

module int_rf
    import exec_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Write port, fed by the ALU result
    input  logic     wr_valid_i,
    input  reg_idx_t wr_rd_idx_i,
    input  word_t    wr_value_i,

    // Operand read ports
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output word_t    rs1_value_o,
    output word_t    rs2_value_o
);

    // Architectural registers
    word_t rf_q [REG_NUM];

    // Synchronous write, x0 forced to zero every cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                rf_q[i] <= '0;
            end
        end else begin
            rf_q[0] <= '0;
            // Writes to x0 are dropped
            if (wr_valid_i && (wr_rd_idx_i != '0)) begin
                rf_q[wr_rd_idx_i] <= wr_value_i;
            end
        end
    end

    // Combinational reads, no bypass of the write in flight
    assign rs1_value_o = rf_q[rs1_idx_i];
    assign rs2_value_o = rf_q[rs2_idx_i];

endmodule

`default_nettype wire

/* alu_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_pipe
    import exec_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Issued instruction and its operands
    input  logic     issue_valid_i,
    input  alu_op_t  op_i,
    input  reg_idx_t rd_i,
    input  word_t    rs1_value_i,
    input  word_t    rs2_value_i,
    input  imm_t     imm_i,

    // Registered result
    output logic     res_valid_o,
    output reg_idx_t res_rd_o,
    output word_t    res_value_o
);

    // Shift amount width, 5 bits for 32-bit words
    localparam int unsigned SHAMT_LEN = $clog2(XLEN);

    // Stage 1 registers
    logic     s1_valid_q;
    alu_op_t  s1_op_q;
    reg_idx_t s1_rd_q;
    word_t    s1_rs1_q;
    word_t    s1_rs2_q;
    imm_t     s1_imm_q;

    // Stage 2 registers
    logic     s2_valid_q;
    reg_idx_t s2_rd_q;
    word_t    s2_value_q;

    word_t               imm_ext;
    logic [SHAMT_LEN-1:0] shamt;
    word_t               alu_res;

    // Valid bits are the only control state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issue_valid_i;
            s2_valid_q <= s1_valid_q;
        end
    end

    // Stage 1 operand capture at the issue edge
    always_ff @(posedge clk_i) begin
        s1_op_q  <= op_i;
        s1_rd_q  <= rd_i;
        s1_rs1_q <= rs1_value_i;
        s1_rs2_q <= rs2_value_i;
        s1_imm_q <= imm_i;
    end

    // Sign-extend the 12-bit immediate
    assign imm_ext = {{(XLEN - IMM_LEN){s1_imm_q[IMM_LEN-1]}}, s1_imm_q};
    assign shamt   = s1_rs2_q[SHAMT_LEN-1:0];

    // Opcode function
    always_comb begin
        unique case (s1_op_q)
            OP_ADD:  alu_res = s1_rs1_q + s1_rs2_q;
            OP_SUB:  alu_res = s1_rs1_q - s1_rs2_q;
            OP_AND:  alu_res = s1_rs1_q & s1_rs2_q;
            OP_OR:   alu_res = s1_rs1_q | s1_rs2_q;
            OP_XOR:  alu_res = s1_rs1_q ^ s1_rs2_q;
            OP_SLL:  alu_res = s1_rs1_q << shamt;
            OP_SRL:  alu_res = s1_rs1_q >> shamt;
            OP_ADDI: alu_res = s1_rs1_q + imm_ext;
            default: alu_res = '0;
        endcase
    end

    // Stage 2 result capture, one edge after issue
    always_ff @(posedge clk_i) begin
        s2_rd_q    <= s1_rd_q;
        s2_value_q <= alu_res;
    end

    assign res_valid_o = s2_valid_q;
    assign res_rd_o    = s2_rd_q;
    assign res_value_o = s2_value_q;

endmodule

`default_nettype wire

/* exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_top
    import exec_pkg::*;
#(
    parameter int unsigned ISSUE_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    // Credit-based instruction channel
    input  logic     instr_valid_i,
    input  alu_op_t  instr_op_i,
    input  reg_idx_t instr_rd_i,
    input  reg_idx_t instr_rs1_i,
    input  reg_idx_t instr_rs2_i,
    input  imm_t     instr_imm_i,
    output logic     instr_credit_o,

    // In-order commit, no back-pressure
    output logic     commit_valid_o,
    output reg_idx_t commit_rd_o,
    output word_t    commit_value_o
);

    // Queue head
    alu_op_t  head_op;
    reg_idx_t head_rd;
    reg_idx_t head_rs1;
    reg_idx_t head_rs2;
    imm_t     head_imm;
    logic     fifo_empty;

    // Issue control
    logic     fifo_pop;
    logic     issue_valid;

    // Operands from the register file
    word_t    rs1_value;
    word_t    rs2_value;

    // ALU result, shared by write-back and commit
    logic     res_valid;
    reg_idx_t res_rd;
    word_t    res_value;

    instr_fifo #(
        .ISSUE_DEPTH (ISSUE_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (instr_valid_i),
        .push_op_i  (instr_op_i),
        .push_rd_i  (instr_rd_i),
        .push_rs1_i (instr_rs1_i),
        .push_rs2_i (instr_rs2_i),
        .push_imm_i (instr_imm_i),
        .pop_i      (fifo_pop),
        .head_op_o  (head_op),
        .head_rd_o  (head_rd),
        .head_rs1_o (head_rs1),
        .head_rs2_o (head_rs2),
        .head_imm_o (head_imm),
        .empty_o    (fifo_empty)
    );

    issue_ctrl u_issue (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .empty_i       (fifo_empty),
        .head_rd_i     (head_rd),
        .head_rs1_i    (head_rs1),
        .head_rs2_i    (head_rs2),
        .pop_o         (fifo_pop),
        .issue_valid_o (issue_valid),
        .credit_o      (instr_credit_o),
        .wb_valid_i    (res_valid),
        .wb_rd_i       (res_rd)
    );

    // Head source indices drive the read ports directly
    int_rf u_rf (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wr_valid_i  (res_valid),
        .wr_rd_idx_i (res_rd),
        .wr_value_i  (res_value),
        .rs1_idx_i   (head_rs1),
        .rs2_idx_i   (head_rs2),
        .rs1_value_o (rs1_value),
        .rs2_value_o (rs2_value)
    );

    alu_pipe u_alu (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid),
        .op_i          (head_op),
        .rd_i          (head_rd),
        .rs1_value_i   (rs1_value),
        .rs2_value_i   (rs2_value),
        .imm_i         (head_imm),
        .res_valid_o   (res_valid),
        .res_rd_o      (res_rd),
        .res_value_o   (res_value)
    );

    // Commit mirrors the write-back port
    assign commit_valid_o = res_valid;
    assign commit_rd_o    = res_rd;
    assign commit_value_o = res_value;

endmodule

`default_nettype wire

/* exec_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_checker
    import exec_pkg::*;
#(
    parameter int unsigned ISSUE_DEPTH = 4
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     push_i,
    input  wire logic     pop_i,
    input  wire logic     credit_i,
    input  wire logic     commit_valid_i,
    input  wire reg_idx_t rs1_idx_i,
    input  wire word_t    rs1_value_i,
    input  wire reg_idx_t rs2_idx_i,
    input  wire word_t    rs2_value_i
);

    localparam int unsigned CNT_LEN = $clog2(ISSUE_DEPTH + 1);

    // Shadow occupancy of the instruction queue
    logic [CNT_LEN-1:0] occupancy_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupancy_q <= '0;
        end else begin
            occupancy_q <= occupancy_q + CNT_LEN'(push_i) - CNT_LEN'(pop_i);
        end
    end

    // Source never pushes into a full queue
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> (occupancy_q < CNT_LEN'(ISSUE_DEPTH)))
        else $error("push into a full instruction queue");

    // Credit and commit outputs stay low in reset
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> (!credit_i && !commit_valid_i))
        else $error("credit or commit output active during reset");

    // Any read of x0 returns zero, whatever was committed to x0 before
    x0_reads_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs1_idx_i != '0 || rs1_value_i == '0) && (rs2_idx_i != '0 || rs2_value_i == '0))
        else $error("read of x0 returned a nonzero value");

endmodule

bind exec_top exec_checker #(
    .ISSUE_DEPTH (ISSUE_DEPTH)
) u_checker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .push_i         (instr_valid_i),
    .pop_i          (fifo_pop),
    .credit_i       (instr_credit_o),
    .commit_valid_i (commit_valid_o),
    .rs1_idx_i      (head_rs1),
    .rs1_value_i    (rs1_value),
    .rs2_idx_i      (head_rs2),
    .rs2_value_i    (rs2_value)
);

`default_nettype wire

/* tb_exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_top
    import exec_pkg::*;
();

    // Cycle limit for every wait loop
    localparam int unsigned TIMEOUT = 200;

    // Queue depth, read from the DUT's own parameter
    int unsigned issue_depth;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    alu_op_t  instr_op;
    reg_idx_t instr_rd;
    reg_idx_t instr_rs1;
    reg_idx_t instr_rs2;
    imm_t     instr_imm;
    logic     instr_credit;
    logic     commit_valid;
    reg_idx_t commit_rd;
    word_t    commit_value;

    // Reference register file and expected commits in program order
    word_t       model_rf [REG_NUM];
    reg_idx_t    exp_rd_q [$];
    word_t       exp_value_q [$];
    int unsigned credits_used = 0;
    int unsigned credits_returned = 0;
    alu_op_t     rr_ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};

    exec_top dut_i (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .instr_valid_i  (instr_valid),
        .instr_op_i     (instr_op),
        .instr_rd_i     (instr_rd),
        .instr_rs1_i    (instr_rs1),
        .instr_rs2_i    (instr_rs2),
        .instr_imm_i    (instr_imm),
        .instr_credit_o (instr_credit),
        .commit_valid_o (commit_valid),
        .commit_rd_o    (commit_rd),
        .commit_value_o (commit_value)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, expected));
        end
    endtask

    // Opcode rules, immediate sign extended from 12 bits
    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b,
                                        input imm_t imm);
        word_t r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_ADDI: r = a + word_t'(int'(imm));
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'($urandom_range(REG_NUM - 1, 1));
    endfunction

    // Wait for a credit, update the model, drive one instruction
    task automatic send(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                        input reg_idx_t rs2, input imm_t imm);
        int unsigned waited = 0;
        word_t result;
        while (credits_used - credits_returned >= issue_depth) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timed out waiting for an instruction credit");
            end
        end
        result = alu_model(op, model_rf[rs1], model_rf[rs2], imm);
        // x0 stays zero in the model
        if (rd != '0) begin
            model_rf[rd] = result;
        end
        exp_rd_q.push_back(rd);
        exp_value_q.push_back(result);
        instr_valid = 1'b1;
        instr_op = op;
        instr_rd = rd;
        instr_rs1 = rs1;
        instr_rs2 = rs2;
        instr_imm = imm;
        credits_used++;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int unsigned waited = 0;
        while (exp_rd_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("timed out waiting for outstanding commits");
            end
        end
    endtask

    // Credit counter and commit monitor, outputs are registered
    always @(posedge clk) begin
        if (rst_n) begin
            if (instr_credit) begin
                credits_returned++;
                if (credits_returned > credits_used) begin
                    stop_run("credit pulse with no instruction outstanding");
                end
            end
            if (commit_valid) begin
                if (exp_rd_q.size() == 0) begin
                    stop_run("commit seen with no instruction outstanding");
                end else begin
                    check_value("commit_rd_o", word_t'(commit_rd), word_t'(exp_rd_q.pop_front()));
                    check_value("commit_value_o", commit_value, exp_value_q.pop_front());
                end
            end
        end
    end

    // Quiet after reset, then adds on never-written registers give zeros
    task automatic test_reset_chain();
        repeat (8) @(negedge clk);
        check_value("instr_credit_o pulses", credits_returned, 0);
        send(OP_ADD, 5'd1, 5'd2, 5'd3, '0);
        send(OP_ADD, 5'd4, 5'd1, 5'd5, '0);
        send(OP_ADD, 5'd6, 5'd4, 5'd1, '0);
        wait_drained();
    endtask

    task automatic test_immediates();
        for (int r = 1; r < REG_NUM; r++) begin
            send(OP_ADDI, reg_idx_t'(r), 5'd0, reg_idx_t'($urandom), imm_t'($urandom));
        end
        wait_drained();
    endtask

    // Random sources, so shift amounts carry high bits too
    task automatic test_alu_ops();
        foreach (rr_ops[i]) begin
            repeat (5) send(rr_ops[i], rand_reg(), reg_idx_t'($urandom), reg_idx_t'($urandom), '0);
        end
        wait_drained();
    endtask

    // Chain through x8 upwards, fillers in x20 upwards
    task automatic test_dependences();
        reg_idx_t prev;
        prev = 5'd1;
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                send(OP_ADDI, reg_idx_t'(8 + i), prev, 5'd0, imm_t'($urandom));
            end else begin
                send(OP_XOR, reg_idx_t'(8 + i), prev, 5'd2, '0);
            end
            send(OP_ADDI, reg_idx_t'(20 + i), 5'd3, 5'd4, imm_t'($urandom));
            prev = reg_idx_t'(8 + i);
        end
        wait_drained();
    endtask

    // Self-dependent chain fills the queue and runs the source out of credits
    task automatic test_credits();
        int unsigned base;
        base = credits_returned;
        check_value("credits outstanding", credits_used - credits_returned, 0);
        send(OP_ADDI, 5'd10, 5'd0, 5'd0, 12'sd3);
        for (int i = 1; i < 2 * issue_depth; i++) begin
            send(OP_ADD, 5'd10, 5'd10, 5'd10, '0);
        end
        wait_drained();
        repeat (4) @(negedge clk);
        check_value("instr_credit_o pulses", credits_returned - base, 2 * issue_depth);
    endtask

    // Writes to x0 commit with rd 0 but leave x0 at zero
    task automatic test_x0();
        send(OP_ADDI, 5'd0, 5'd0, 5'd0, 12'sh123);
        send(OP_ADD, 5'd0, 5'd31, 5'd30, '0);
        send(OP_OR, 5'd11, 5'd0, 5'd0, '0);
        send(OP_ADDI, 5'd12, 5'd0, 5'd0, 12'sh7ff);
        wait_drained();
    endtask

    initial begin
        void'($urandom(32'hd239_5f46));
        issue_depth = dut_i.ISSUE_DEPTH;
        for (int r = 0; r < REG_NUM; r++) begin
            model_rf[r] = '0;
        end
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr_op = OP_ADD;
        instr_rd = '0;
        instr_rs1 = '0;
        instr_rs2 = '0;
        instr_imm = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_chain();
        test_immediates();
        test_alu_ops();
        test_dependences();
        test_credits();
        test_x0();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
exec_pkg.sv
instr_fifo.sv
issue_ctrl.sv
int_rf.sv
alu_pipe.sv
exec_top.sv
exec_checker.sv
tb_exec_top.sv

/* run.sh */
#!/bin/sh
# Build and run the execution cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_top \
    -f list.f -o sim_exec; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_exec)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
